/* src/av_settings.svh */
`ifndef AV_SETTINGS_SVH
`define AV_SETTINGS_SVH

// Luma sample from the machine
`define AV_LUMA_W 8

// Per channel on the VGA pins
`define AV_COLOR_W 6

// Status word from the I/O controller
`define AV_STATUS_W 32

// Audio sample into the DAC
`define AV_AUDIO_W 8

// First byte of a status write frame
`define AV_OP_STATUS 8'h1E

`endif

/* src/av_pkg.sv */
`include "av_settings.svh"

package av_pkg;

	// One pixel as the machine produces it
	typedef struct packed {
		logic valid;
		logic blank;
		logic hs;
		logic vs;
		logic [`AV_LUMA_W-1:0] luma;
	} luma_px_t;

	// One pixel toward the VGA pins
	typedef struct packed {
		logic valid;
		logic hs;
		logic vs;
		logic [`AV_COLOR_W-1:0] r;
		logic [`AV_COLOR_W-1:0] g;
		logic [`AV_COLOR_W-1:0] b;
	} rgb_px_t;

	// Status bits 3:2
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1,
		SCAN_50  = 2'd2,
		SCAN_75  = 2'd3
	} scan_mode_e;

	// First byte of an SPI frame
	typedef enum logic [7:0] {
		OP_NOP    = 8'h00,
		OP_STATUS = `AV_OP_STATUS
	} spi_op_e;

endpackage

/* src/spi_status_rx.sv */
`include "av_settings.svh"

module spi_status_rx (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    sck,
	input  logic                    ss_n,
	input  logic                    mosi,
	output logic [`AV_STATUS_W-1:0] status
);
	localparam int FRAME_BITS = 8 + `AV_STATUS_W; // Opcode then payload
	localparam int CNT_W = $clog2(FRAME_BITS + 1);

	logic [1:0] sck_sync;
	logic [1:0] mosi_sync;
	logic [1:0] ss_sync;
	logic sck_q;
	logic sck_rise;
	logic [7:0] opcode_next;
	logic [FRAME_BITS-1:0] frame;
	logic [CNT_W-1:0] bit_cnt;
	logic is_status;
	logic frame_done;

	// Two flops per serial input
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sck_sync <= 2'b00;
			mosi_sync <= 2'b00;
			ss_sync <= 2'b11; // Idle deselected
			sck_q <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			mosi_sync <= {mosi_sync[0], mosi};
			ss_sync <= {ss_sync[0], ss_n};
			sck_q <= sck_sync[1];
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_q;
	assign opcode_next = {frame[6:0], mosi_sync[1]}; // Byte as it completes

	// MSB first
	always_ff @(posedge clk_sys) begin
		if (sck_rise && bit_cnt != CNT_W'(FRAME_BITS))
			frame <= {frame[FRAME_BITS-2:0], mosi_sync[1]};
	end

	// Frame control, cleared while deselected
	always_ff @(posedge clk_sys) begin
		if (!rst_n || ss_sync[1]) begin
			bit_cnt <= '0;
			is_status <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (sck_rise && bit_cnt != CNT_W'(FRAME_BITS)) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == CNT_W'(7))
					is_status <= (opcode_next == av_pkg::OP_STATUS);
				if (bit_cnt == CNT_W'(FRAME_BITS - 1))
					frame_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			status <= '0;
		else if (frame_done && is_status)
			status <= frame[`AV_STATUS_W-1:0]; // Other opcodes are dropped
	end

endmodule

/* src/video_blank_stage.sv */
`include "av_settings.svh"

module video_blank_stage (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  av_pkg::luma_px_t  pix_in,
	output av_pkg::rgb_px_t   pix_out
);
	logic show_px;
	logic [`AV_COLOR_W-1:0] gray;

	// Only visible pixels carry color
	assign show_px = pix_in.valid & ~pix_in.blank;

	always_comb begin
		if (show_px)
			gray = pix_in.luma[`AV_LUMA_W-1 -: `AV_COLOR_W]; // Top luma bits
		else
			gray = '0;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pix_out <= '0;
		end else begin
			pix_out.valid <= pix_in.valid;
			pix_out.hs <= pix_in.hs;
			pix_out.vs <= pix_in.vs;
			pix_out.r <= gray;
			pix_out.g <= gray;
			pix_out.b <= gray;
		end
	end

endmodule

/* src/video_scanline_stage.sv */
`include "av_settings.svh"

module video_scanline_stage (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  av_pkg::scan_mode_e  mode,
	input  av_pkg::rgb_px_t     pix_in,
	output av_pkg::rgb_px_t     pix_out
);
	logic hs_prev;
	logic hs_rise;
	logic line_odd;
	logic line_odd_next;
	av_pkg::rgb_px_t pix_dim;

	// Darken one channel by the selected amount
	function automatic logic [`AV_COLOR_W-1:0] dim_channel(
		input logic [`AV_COLOR_W-1:0] c,
		input av_pkg::scan_mode_e     m
	);
		logic [`AV_COLOR_W-1:0] res;
		case (m)
			av_pkg::SCAN_25: res = c - (c >> 2);
			av_pkg::SCAN_50: res = c >> 1;
			av_pkg::SCAN_75: res = c >> 2;
			default:         res = c;
		endcase
		return res;
	endfunction

	assign hs_rise = pix_in.hs & ~hs_prev;
	assign line_odd_next = line_odd ^ hs_rise; // Edge pixel sees new parity

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_prev <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_prev <= pix_in.hs;
			line_odd <= line_odd_next;
		end
	end

	always_comb begin
		pix_dim = pix_in;
		if (line_odd_next) begin
			pix_dim.r = dim_channel(pix_in.r, mode);
			pix_dim.g = dim_channel(pix_in.g, mode);
			pix_dim.b = dim_channel(pix_in.b, mode);
		end
	end

	// Syncs and valid pass as they are
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			pix_out <= '0;
		else
			pix_out <= pix_dim;
	end

endmodule

/* src/sigma_delta_dac.sv */
`include "av_settings.svh"

module sigma_delta_dac #(
	parameter int width = `AV_AUDIO_W
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic [width-1:0] sample,
	output logic             dac_out
);
	logic [width-1:0] acc;
	logic [width:0] sum;

	// Carry out is the pulse density
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
			dac_out <= 1'b0;
		end else begin
			acc <= sum[width-1:0];
			dac_out <= sum[width];
		end
	end

endmodule

/* src/av_top.sv */
`include "av_settings.svh"

module av_top (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   spi_sck,
	input  logic                   spi_ss_n,
	input  logic                   spi_mosi,
	input  av_pkg::luma_px_t       pix_in,
	input  logic [`AV_AUDIO_W-1:0] audio,
	output av_pkg::rgb_px_t        pix_out,
	output logic                   audio_out,
	output logic                   core_rst_n
);
	logic [`AV_STATUS_W-1:0] status;
	av_pkg::scan_mode_e scan_mode;
	av_pkg::rgb_px_t pix_mid;
	logic core_hold;

	spi_status_rx u_spi_status_rx (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sck     (spi_sck),
		.ss_n    (spi_ss_n),
		.mosi    (spi_mosi),
		.status  (status)
	);

	assign scan_mode = av_pkg::scan_mode_e'(status[3:2]); // Off, 25%, 50%, 75%

	video_blank_stage u_video_blank_stage (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pix_in  (pix_in),
		.pix_out (pix_mid)
	);

	video_scanline_stage u_video_scanline_stage (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.mode    (scan_mode),
		.pix_in  (pix_mid),
		.pix_out (pix_out)
	);

	sigma_delta_dac #(
		.width (`AV_AUDIO_W)
	) u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio),
		.dac_out (audio_out)
	);

	// Menu reset bits
	assign core_hold = status[0] | status[9];

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			core_rst_n <= 1'b0;
		else
			core_rst_n <= ~core_hold;
	end

endmodule

/* tb/av_sva.sv */
module av_sva (
	input logic              clk_sys,
	input logic              rst_n,
	input av_pkg::luma_px_t  pix_in,
	input av_pkg::rgb_px_t   pix_out,
	input logic              core_rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// Core held in reset while the board reset is low
	property p_core_rst_held;
		@(posedge clk_sys) !rst_n |=> !core_rst_n;
	endproperty

	// Two register stages between pix_in and pix_out
	property p_valid_latency;
		@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n, 1) && $past(rst_n, 2) |-> pix_out.valid == $past(pix_in.valid, 2);
	endproperty

	property p_hs_latency;
		@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n, 1) && $past(rst_n, 2) |-> pix_out.hs == $past(pix_in.hs, 2);
	endproperty

	property p_blank_black;
		@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n, 1) && $past(rst_n, 2) && $past(pix_in.blank, 2)
			|-> pix_out.r == '0 && pix_out.g == '0 && pix_out.b == '0;
	endproperty

	a_core_rst_held: assert property (p_core_rst_held)
		else $error("core_rst_n high while rst_n low");
	a_valid_latency: assert property (p_valid_latency)
		else $error("pix_out.valid does not follow pix_in.valid by two cycles");
	a_hs_latency: assert property (p_hs_latency)
		else $error("pix_out.hs does not follow pix_in.hs by two cycles");
	a_blank_black: assert property (p_blank_black)
		else $error("color during blanking");

endmodule

bind av_top av_sva u_av_sva (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.pix_in     (pix_in),
	.pix_out    (pix_out),
	.core_rst_n (core_rst_n)
);

/* tb/av_tb.sv */
`include "av_settings.svh"

module av_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_SCK = 4; // clk_sys cycles per sck half period
	localparam int NUM_ROWS = 19;
	localparam int FRAME_BITS = 8 + `AV_STATUS_W;

	typedef struct {
		logic [`AV_STATUS_W-1:0] status;
		av_pkg::spi_op_e op;
		int nbits;
		logic [`AV_LUMA_W-1:0] luma;
		logic blank;
		logic odd;
		logic [`AV_COLOR_W-1:0] exp_ch;
		logic exp_rst_n;
	} row_t;

	logic clk_sys;
	logic rst_n;
	logic spi_sck;
	logic spi_ss_n;
	logic spi_mosi;
	av_pkg::luma_px_t pix_in;
	logic [`AV_AUDIO_W-1:0] audio;
	av_pkg::rgb_px_t pix_out;
	logic audio_out;
	logic core_rst_n;

	row_t rows [NUM_ROWS];
	logic line_odd; // Parity the scanline stage should hold
	int seed;

	av_top u_av_top (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.spi_sck    (spi_sck),
		.spi_ss_n   (spi_ss_n),
		.spi_mosi   (spi_mosi),
		.pix_in     (pix_in),
		.audio      (audio),
		.pix_out    (pix_out),
		.audio_out  (audio_out),
		.core_rst_n (core_rst_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic tick();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) tick();
	endtask

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			stop_on_failure($sformatf("Error at %0d ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	function automatic av_pkg::luma_px_t make_px(
		input logic valid,
		input logic blank,
		input logic hs,
		input logic [`AV_LUMA_W-1:0] luma
	);
		av_pkg::luma_px_t px;
		px = '0;
		px.valid = valid;
		px.blank = blank;
		px.hs = hs;
		px.luma = luma;
		return px;
	endfunction

	// Reference for one output channel
	function automatic logic [`AV_COLOR_W-1:0] expected_channel(
		input av_pkg::luma_px_t   px,
		input logic               odd,
		input av_pkg::scan_mode_e mode
	);
		int c;
		c = 0;
		if (px.valid && !px.blank)
			c = int'(px.luma) / (1 << (`AV_LUMA_W - `AV_COLOR_W));
		if (odd) begin
			case (mode)
				av_pkg::SCAN_25: c = c - c / 4;
				av_pkg::SCAN_50: c = c / 2;
				av_pkg::SCAN_75: c = c / 4;
				default:         c = c;
			endcase
		end
		return c[`AV_COLOR_W-1:0];
	endfunction

	task automatic spi_send(input av_pkg::spi_op_e op, input logic [`AV_STATUS_W-1:0] data,
		input int nbits);
		logic [FRAME_BITS-1:0] frame;
		frame = {op, data};
		spi_ss_n = 1'b0;
		wait_cycles(HALF_SCK);
		for (int i = 0; i < nbits; i++) begin
			spi_mosi = frame[FRAME_BITS-1-i]; // MSB first
			wait_cycles(HALF_SCK);
			spi_sck = 1'b1;
			wait_cycles(HALF_SCK);
			spi_sck = 1'b0;
		end
		wait_cycles(HALF_SCK);
		spi_ss_n = 1'b1;
		spi_mosi = 1'b0;
		wait_cycles(HALF_SCK);
	endtask

	task automatic wait_core_rst(input logic level, input int limit);
		int n;
		n = 0;
		while (core_rst_n !== level && n < limit) begin
			tick();
			n++;
		end
		if (core_rst_n !== level)
			stop_on_failure($sformatf("Timed out waiting for core_rst_n to become %0b", level));
	endtask

	// One hs pulse flips the line parity
	task automatic set_parity(input logic odd);
		if (line_odd != odd) begin
			pix_in = make_px(1'b0, 1'b1, 1'b1, '0);
			tick();
			pix_in = make_px(1'b0, 1'b1, 1'b0, '0);
			tick();
			line_odd = ~line_odd;
		end
	endtask

	task automatic check_pixel(input logic exp_valid, input logic exp_vs,
		input logic [`AV_COLOR_W-1:0] exp_ch, input string what);
		check_value(32'(pix_out.valid), 32'(exp_valid), {what, " valid"});
		check_value(32'(pix_out.hs), 32'd0, {what, " hs"});
		check_value(32'(pix_out.vs), 32'(exp_vs), {what, " vs"});
		check_value(32'(pix_out.r), 32'(exp_ch), {what, " red"});
		check_value(32'(pix_out.g), 32'(exp_ch), {what, " green"});
		check_value(32'(pix_out.b), 32'(exp_ch), {what, " blue"});
	endtask

	// Back to back pixels, output checked two cycles later
	task automatic run_noise(input int count, input av_pkg::scan_mode_e mode);
		logic [`AV_COLOR_W-1:0] exp_ch [$];
		logic exp_valid [$];
		logic exp_vs [$];
		logic [31:0] r;
		av_pkg::luma_px_t px;
		for (int k = 0; k < count + 2; k++) begin
			if (k >= 2)
				check_pixel(exp_valid.pop_front(), exp_vs.pop_front(), exp_ch.pop_front(),
					"noise pixel");
			if (k < count) begin
				r = $random(seed);
				px = make_px(r[8] | r[9], r[10] & r[11], 1'b0, r[`AV_LUMA_W-1:0]);
				px.vs = r[12];
				exp_valid.push_back(px.valid);
				exp_vs.push_back(px.vs);
				exp_ch.push_back(expected_channel(px, line_odd, mode));
			end else begin
				px = make_px(1'b0, 1'b1, 1'b0, '0);
			end
			pix_in = px;
			tick();
		end
	endtask

	task automatic check_audio(input logic [`AV_AUDIO_W-1:0] level);
		int highs;
		audio = level;
		wait_cycles(256); // Settle
		highs = 0;
		for (int i = 0; i < 256; i++) begin
			tick();
			if (audio_out)
				highs++;
		end
		check_value(highs, 32'(level), "audio_out highs in 256 cycles");
	endtask

	// status, opcode, bits sent, luma, blank, odd line, expected channel, expected core_rst_n
	task automatic load_table();
		rows[0]  = '{32'h000, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b0, 6'd45, 1'b1};
		rows[1]  = '{32'h000, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b1, 6'd45, 1'b1};
		rows[2]  = '{32'h000, av_pkg::OP_STATUS, 40, 8'hB4, 1'b1, 1'b0, 6'd0, 1'b1};
		rows[3]  = '{32'h004, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b0, 6'd45, 1'b1};
		rows[4]  = '{32'h004, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b1, 6'd34, 1'b1};
		rows[5]  = '{32'h004, av_pkg::OP_STATUS, 40, 8'hFF, 1'b0, 1'b1, 6'd48, 1'b1};
		rows[6]  = '{32'h008, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b1, 6'd22, 1'b1};
		rows[7]  = '{32'h008, av_pkg::OP_STATUS, 40, 8'hFF, 1'b0, 1'b0, 6'd63, 1'b1};
		rows[8]  = '{32'h20D, av_pkg::OP_NOP, 40, 8'hFF, 1'b0, 1'b1, 6'd31, 1'b1}; // Ignored
		rows[9]  = '{32'h20D, av_pkg::OP_STATUS, 20, 8'hFF, 1'b0, 1'b1, 6'd31, 1'b1}; // Aborted
		rows[10] = '{32'h008, av_pkg::OP_STATUS, 40, 8'h0C, 1'b0, 1'b1, 6'd1, 1'b1};
		rows[11] = '{32'h00C, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b1, 6'd11, 1'b1};
		rows[12] = '{32'h00C, av_pkg::OP_STATUS, 40, 8'hFF, 1'b0, 1'b1, 6'd15, 1'b1};
		rows[13] = '{32'h00C, av_pkg::OP_STATUS, 40, 8'h0C, 1'b0, 1'b1, 6'd0, 1'b1};
		rows[14] = '{32'h001, av_pkg::OP_STATUS, 40, 8'hB4, 1'b0, 1'b1, 6'd45, 1'b0};
		rows[15] = '{32'h200, av_pkg::OP_STATUS, 40, 8'hFF, 1'b0, 1'b1, 6'd63, 1'b0};
		rows[16] = '{32'h20D, av_pkg::OP_STATUS, 40, 8'hFF, 1'b0, 1'b1, 6'd15, 1'b0};
		rows[17] = '{32'h000, av_pkg::OP_NOP, 40, 8'hFF, 1'b0, 1'b1, 6'd15, 1'b0};
		rows[18] = '{32'h008, av_pkg::OP_STATUS, 40, 8'hFF, 1'b1, 1'b1, 6'd0, 1'b1};
	endtask

	initial begin
		logic [`AV_AUDIO_W-1:0] levels [4];
		seed = 32'h7637;
		rst_n = 1'b0;
		spi_sck = 1'b0;
		spi_ss_n = 1'b1;
		spi_mosi = 1'b0;
		pix_in = '0;
		audio = '0;
		line_odd = 1'b0;
		levels[0] = 8'd0;
		levels[1] = 8'd64;
		levels[2] = 8'd200;
		levels[3] = 8'd255;
		load_table();

		wait_cycles(2);
		check_value(32'(pix_out), 32'd0, "pix_out in reset");
		check_value(32'(audio_out), 32'd0, "audio_out in reset");
		check_value(32'(core_rst_n), 32'd0, "core_rst_n in reset");
		rst_n = 1'b1;
		wait_core_rst(1'b1, 8);

		run_noise(24, av_pkg::SCAN_OFF);

		for (int i = 0; i < NUM_ROWS; i++) begin
			spi_send(rows[i].op, rows[i].status, rows[i].nbits);
			wait_core_rst(rows[i].exp_rst_n, 16);
			set_parity(rows[i].odd);
			pix_in = make_px(1'b1, rows[i].blank, 1'b0, rows[i].luma);
			tick();
			pix_in = make_px(1'b0, 1'b1, 1'b0, '0);
			tick();
			check_pixel(1'b1, 1'b0, rows[i].exp_ch, $sformatf("row %0d", i));
		end

		// Last row left SCAN_50 selected
		run_noise(24, av_pkg::SCAN_50);

		foreach (levels[i])
			check_audio(levels[i]);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* build.f */
+incdir+src
src/av_pkg.sv
src/spi_status_rx.sv
src/video_blank_stage.sv
src/video_scanline_stage.sv
src/sigma_delta_dac.sv
src/av_top.sv
tb/av_sva.sv
tb/av_tb.sv

/* Makefile */
# Verilator build and run for the A/V subsystem testbench

VERILATOR ?= verilator
TOP ?= av_tb
OBJ_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard src/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
